// File: Makefile
# Verilator flow for the Tiny86 control path
TOP := tb_tiny86_ctrl
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

obj_dir/V$(TOP): files.f rtl/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

# The run fails when the log holds the fail message or lacks the pass message
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
+incdir+test
rtl/tiny86_isa_pkg.sv
rtl/tiny86_bus_pkg.sv
rtl/cfu.sv
rtl/arch_regs.sv
rtl/retire_stage.sv
rtl/tiny86_ctrl_top.sv
test/tb_tiny86_ctrl.sv

// File: rtl/arch_regs.sv
//------------------
// Tiny86 architectural registers EIP, EFLAGS and ECX behind an APB slave
// The retire stage updates EIP and ECX through side ports that win over
// an APB write to the same register in the same cycle
//------------------
`timescale 1ns/1ps
`default_nettype none

module arch_regs (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire tiny86_bus_pkg::apb_req_t          apb_req,
  output tiny86_bus_pkg::apb_rsp_t               apb_rsp,
  input  wire                                    eip_we,
  input  wire [tiny86_isa_pkg::XLEN-1:0]         eip_wdata,
  input  wire                                    ecx_dec,
  output logic [tiny86_isa_pkg::XLEN-1:0]        eip,
  output logic [tiny86_isa_pkg::XLEN-1:0]        eflags,
  output logic                                   ecx_is_zero,
  output logic                                   ecx_is_one
);

  logic [tiny86_isa_pkg::XLEN-1:0] eip_q;
  logic [tiny86_isa_pkg::XLEN-1:0] eflags_q;
  logic [tiny86_isa_pkg::XLEN-1:0] ecx_q;

  // APB access phase and address decode
  logic access;
  logic hit_eip;
  logic hit_eflags;
  logic hit_ecx;
  logic addr_ok;
  logic apb_wr;

  assign access     = apb_req.psel & apb_req.penable;
  assign hit_eip    = apb_req.paddr == tiny86_bus_pkg::REG_EIP;
  assign hit_eflags = apb_req.paddr == tiny86_bus_pkg::REG_EFLAGS;
  assign hit_ecx    = apb_req.paddr == tiny86_bus_pkg::REG_ECX;
  assign addr_ok    = hit_eip | hit_eflags | hit_ecx;

  // A write lands at the end of the access phase, only for a mapped offset
  assign apb_wr = access & apb_req.pwrite & addr_ok;

  // No wait states, so the slave is always ready in the access phase
  assign apb_rsp.pready  = access;
  assign apb_rsp.pslverr = access & !addr_ok;

  // Read data is the live register value
  always_comb begin
    if (hit_eip) begin
      apb_rsp.prdata = eip_q;
    end else if (hit_eflags) begin
      apb_rsp.prdata = eflags_q;
    end else if (hit_ecx) begin
      apb_rsp.prdata = ecx_q;
    end else begin
      apb_rsp.prdata = '0;
    end
  end

  // EIP follows the retire stage first and software second
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      eip_q <= '0;
    end else if (eip_we) begin
      eip_q <= eip_wdata;
    end else if (apb_wr && hit_eip) begin
      eip_q <= apb_req.pwdata;
    end
  end

  // There is no ALU in this subsystem, EFLAGS only moves over APB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      eflags_q <= '0;
    end else if (apb_wr && hit_eflags) begin
      eflags_q <= apb_req.pwdata;
    end
  end

  // ECX counts down for the loop family and wraps from zero to all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ecx_q <= '0;
    end else if (ecx_dec) begin
      ecx_q <= ecx_q - 1'b1;
    end else if (apb_wr && hit_ecx) begin
      ecx_q <= apb_req.pwdata;
    end
  end

  assign eip         = eip_q;
  assign eflags      = eflags_q;
  assign ecx_is_zero = ecx_q == '0;
  assign ecx_is_one  = ecx_q == {{(tiny86_isa_pkg::XLEN - 1){1'b0}}, 1'b1};

  // The master never raises penable outside a selected transfer
  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (!rst_n)
    apb_req.penable |-> apb_req.psel
  );

  // The retire stage always hands over a resolved EIP
  a_eip_wdata_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    eip_we |-> !$isunknown(eip_wdata)
  );

endmodule

`default_nettype wire

// File: rtl/cfu.sv
//------------------
// Tiny86 control flow unit, purely combinational
// Picks the next EIP and flags a taken transfer for each opcode
// Used as a leaf inside the retire stage
//------------------
`timescale 1ns/1ps
`default_nettype none

module cfu (
  input  wire tiny86_isa_pkg::opcode_e                opc,
  input  wire [tiny86_isa_pkg::XLEN-1:0]              eflags,
  input  wire                                         ecx_is_zero,
  input  wire                                         ecx_is_one,
  input  wire [tiny86_isa_pkg::XLEN-1:0]              eip,
  input  wire [tiny86_isa_pkg::ILEN_W-1:0]            instr_len,
  input  wire [tiny86_isa_pkg::XLEN-1:0]              address,
  output logic [tiny86_isa_pkg::XLEN-1:0]             next_eip,
  output logic                                        taken
);

  // Short names for the flags that the conditions use
  logic cf;
  logic pf;
  logic zf;
  logic sf;
  logic of;

  // Condition result, unconditional transfer and absolute target marks
  logic cc_eval;
  logic xfer_uncond;
  logic xfer_abs;

  logic [tiny86_isa_pkg::XLEN-1:0] seq_eip;
  logic [tiny86_isa_pkg::XLEN-1:0] xfer_eip;

  assign cf = eflags[tiny86_isa_pkg::EFLAGS_CF];
  assign pf = eflags[tiny86_isa_pkg::EFLAGS_PF];
  assign zf = eflags[tiny86_isa_pkg::EFLAGS_ZF];
  assign sf = eflags[tiny86_isa_pkg::EFLAGS_SF];
  assign of = eflags[tiny86_isa_pkg::EFLAGS_OF];

  // Decode the opcode into a condition and a transfer kind
  always_comb begin
    cc_eval     = 1'b0;
    xfer_uncond = 1'b0;
    xfer_abs    = 1'b0;
    case (opc)
      tiny86_isa_pkg::JO:     cc_eval = of;
      tiny86_isa_pkg::JNO:    cc_eval = !of;
      tiny86_isa_pkg::JB:     cc_eval = cf;
      tiny86_isa_pkg::JAE:    cc_eval = !cf;
      tiny86_isa_pkg::JE:     cc_eval = zf;
      tiny86_isa_pkg::JNE:    cc_eval = !zf;
      tiny86_isa_pkg::JBE:    cc_eval = cf | zf;
      tiny86_isa_pkg::JA:     cc_eval = !cf & !zf;
      tiny86_isa_pkg::JS:     cc_eval = sf;
      tiny86_isa_pkg::JNS:    cc_eval = !sf;
      tiny86_isa_pkg::JP:     cc_eval = pf;
      tiny86_isa_pkg::JNP:    cc_eval = !pf;
      tiny86_isa_pkg::JL:     cc_eval = sf != of;
      tiny86_isa_pkg::JNL:    cc_eval = sf == of;
      tiny86_isa_pkg::JLE:    cc_eval = zf | (sf != of);
      tiny86_isa_pkg::JG:     cc_eval = !zf & (sf == of);
      tiny86_isa_pkg::JCXZ:   cc_eval = ecx_is_zero;
      // ECX is decremented first, so the loop runs on while the old value was not one
      // An old value of zero wraps to all ones and keeps looping
      tiny86_isa_pkg::LOOP:   cc_eval = !ecx_is_one;
      tiny86_isa_pkg::LOOPE:  cc_eval = !ecx_is_one & zf;
      tiny86_isa_pkg::LOOPNE: cc_eval = !ecx_is_one & !zf;
      tiny86_isa_pkg::CALLr,
      tiny86_isa_pkg::JMPr:   xfer_uncond = 1'b1;
      tiny86_isa_pkg::CALLi,
      tiny86_isa_pkg::JMPi,
      tiny86_isa_pkg::RET: begin
        xfer_uncond = 1'b1;
        xfer_abs    = 1'b1;
      end
      // NOP and ALU fall through in program order
      default: begin
        cc_eval     = 1'b0;
        xfer_uncond = 1'b0;
        xfer_abs    = 1'b0;
      end
    endcase
  end

  // Address of the following instruction in program order
  assign seq_eip = eip + {{(tiny86_isa_pkg::XLEN - tiny86_isa_pkg::ILEN_W){1'b0}}, instr_len};

  // Relative targets are measured from the sequential EIP
  assign xfer_eip = xfer_abs ? address : seq_eip + address;

  assign taken    = cc_eval | xfer_uncond;
  assign next_eip = taken ? xfer_eip : seq_eip;

endmodule

`default_nettype wire

// File: rtl/retire_stage.sv
//------------------
// Tiny86 retire stage with a single commit slot
// Accepts one instruction per cycle, resolves its next EIP with the cfu,
// updates EIP and ECX and presents a commit record one cycle later
//------------------
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire tiny86_isa_pkg::instr_t            instr,
  input  wire                                    instr_valid,
  output logic                                   instr_ready,
  input  wire [tiny86_isa_pkg::XLEN-1:0]         eip,
  input  wire [tiny86_isa_pkg::XLEN-1:0]         eflags,
  input  wire                                    ecx_is_zero,
  input  wire                                    ecx_is_one,
  output logic                                   eip_we,
  output logic [tiny86_isa_pkg::XLEN-1:0]        eip_wdata,
  output logic                                   ecx_dec,
  output tiny86_isa_pkg::commit_t                commit,
  output logic                                   commit_valid,
  input  wire                                    commit_ready
);

  logic                            accept;
  logic                            is_loop;
  logic [tiny86_isa_pkg::XLEN-1:0] cfu_next_eip;
  logic                            cfu_taken;

  // Next EIP is resolved in the same cycle the instruction is offered
  cfu u_cfu (
    .opc         (instr.opc),
    .eflags      (eflags),
    .ecx_is_zero (ecx_is_zero),
    .ecx_is_one  (ecx_is_one),
    .eip         (eip),
    .instr_len   (instr.instr_len),
    .address     (instr.address),
    .next_eip    (cfu_next_eip),
    .taken       (cfu_taken)
  );

  // The slot can take a new record unless it is full and stalled
  assign instr_ready = !(commit_valid && !commit_ready);
  assign accept      = instr_valid && instr_ready;

  assign is_loop = instr.opc inside {tiny86_isa_pkg::LOOP, tiny86_isa_pkg::LOOPE,
                                     tiny86_isa_pkg::LOOPNE};

  // Architectural updates happen in the accept cycle itself
  assign eip_we    = accept;
  assign eip_wdata = cfu_next_eip;
  assign ecx_dec   = accept && is_loop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_valid <= 1'b0;
    end else if (accept) begin
      commit_valid <= 1'b1;
    end else if (commit_ready) begin
      commit_valid <= 1'b0;
    end
  end

  // Record keeps the EIP the instruction ran at
  always_ff @(posedge clk) begin
    if (accept) begin
      commit <= '{eip: eip, next_eip: cfu_next_eip, taken: cfu_taken};
    end
  end

  // A stalled record must be held until the sink takes it
  a_commit_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    commit_valid && !commit_ready |=> commit_valid && $stable(commit)
  );

endmodule

`default_nettype wire

// File: rtl/tiny86_bus_pkg.sv
//------------------
// APB definitions for the Tiny86 architectural register block
// Request and response records plus the register map offsets
//------------------
`default_nettype none

package tiny86_bus_pkg;

  // APB address and data widths used by the register block
  localparam int unsigned APB_AW = 4;
  localparam int unsigned APB_DW = 32;

  // Register map, byte offsets on the APB side
  localparam logic [APB_AW-1:0] REG_EIP    = 4'h0;
  localparam logic [APB_AW-1:0] REG_EFLAGS = 4'h4;
  localparam logic [APB_AW-1:0] REG_ECX    = 4'h8;

  // Signals driven by the APB master
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  // Signals driven back by the slave
  typedef struct packed {
    logic              pready;
    logic [APB_DW-1:0] prdata;
    logic              pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/tiny86_ctrl_top.sv
//------------------
// Tiny86 EIP control path top level
// Joins the architectural register block and the retire stage
//------------------
`timescale 1ns/1ps
`default_nettype none

module tiny86_ctrl_top (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire tiny86_bus_pkg::apb_req_t          apb_req,
  output tiny86_bus_pkg::apb_rsp_t               apb_rsp,
  input  wire tiny86_isa_pkg::instr_t            instr,
  input  wire                                    instr_valid,
  output logic                                   instr_ready,
  output tiny86_isa_pkg::commit_t                commit,
  output logic                                   commit_valid,
  input  wire                                    commit_ready
);

  // Register state as seen by the retire stage
  logic [tiny86_isa_pkg::XLEN-1:0] eip;
  logic [tiny86_isa_pkg::XLEN-1:0] eflags;
  logic                            ecx_is_zero;
  logic                            ecx_is_one;

  // Updates flowing back from retire
  logic                            eip_we;
  logic [tiny86_isa_pkg::XLEN-1:0] eip_wdata;
  logic                            ecx_dec;

  arch_regs u_arch_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .eip_we      (eip_we),
    .eip_wdata   (eip_wdata),
    .ecx_dec     (ecx_dec),
    .eip         (eip),
    .eflags      (eflags),
    .ecx_is_zero (ecx_is_zero),
    .ecx_is_one  (ecx_is_one)
  );

  retire_stage u_retire_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .eip          (eip),
    .eflags       (eflags),
    .ecx_is_zero  (ecx_is_zero),
    .ecx_is_one   (ecx_is_one),
    .eip_we       (eip_we),
    .eip_wdata    (eip_wdata),
    .ecx_dec      (ecx_dec),
    .commit       (commit),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready)
  );

endmodule

`default_nettype wire

// File: rtl/tiny86_isa_pkg.sv
//------------------
// Tiny86 instruction set definitions shared by the control path
// Holds the opcode encoding, the EFLAGS bit map and the instruction and
// commit records that travel between the retire stage and its neighbours
//------------------
`default_nettype none

package tiny86_isa_pkg;

  // Architectural register width
  localparam int unsigned XLEN = 32;

  // Width of the instruction length field in bytes
  localparam int unsigned ILEN_W = 4;

  // Bit positions inside EFLAGS that the condition codes look at
  localparam int unsigned EFLAGS_CF = 0;
  localparam int unsigned EFLAGS_PF = 2;
  localparam int unsigned EFLAGS_ZF = 6;
  localparam int unsigned EFLAGS_SF = 7;
  localparam int unsigned EFLAGS_OF = 11;

  // Opcodes as seen by the control path after decode
  // NOP and ALU never touch control flow
  typedef enum logic [6:0] {
    NOP,
    ALU,
    // Conditional jumps, all relative to the sequential EIP
    JO,
    JNO,
    JB,
    JAE,
    JE,
    JNE,
    JBE,
    JA,
    JS,
    JNS,
    JP,
    JNP,
    JL,
    JNL,
    JLE,
    JG,
    JCXZ,
    // Counted loops, these also decrement ECX
    LOOP,
    LOOPE,
    LOOPNE,
    // Unconditional relative transfers
    CALLr,
    JMPr,
    // Unconditional absolute transfers
    CALLi,
    JMPi,
    RET
  } opcode_e;

  // Decoded instruction as handed to the retire stage
  typedef struct packed {
    opcode_e           opc;
    logic [ILEN_W-1:0] instr_len;
    logic [XLEN-1:0]   address;
  } instr_t;

  // One record per retired instruction
  // eip is the EIP the instruction ran at, next_eip is where flow went
  typedef struct packed {
    logic [XLEN-1:0] eip;
    logic [XLEN-1:0] next_eip;
    logic            taken;
  } commit_t;

endpackage

`default_nettype wire

// File: test/tb_ctrl_vectors.svh
//------------------
// Stimulus and expected results for the Tiny86 control path testbench
// Included inside the testbench module, one row per retired instruction
//------------------
`ifndef TB_CTRL_VECTORS_SVH
`define TB_CTRL_VECTORS_SVH

// Columns: ld (bit 0 loads EFLAGS, bit 1 loads ECX), EFLAGS, ECX, instruction
// {opc, len, address}, expected commit {eip, next_eip, taken}, expected ECX after it
typedef struct packed {
  logic [1:0]              ld;
  logic [31:0]             eflags;
  logic [31:0]             ecx;
  tiny86_isa_pkg::instr_t  instr;
  tiny86_isa_pkg::commit_t exp_commit;
  logic [31:0]             exp_ecx;
} vec_t;

localparam int NUM_VECS = 52;

// Flag masks used below: CF 'h001, PF 'h004, ZF 'h040, SF 'h080, OF 'h800
vec_t vecs [NUM_VECS] = '{
  // Sequential flow from the reset EIP
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::NOP, 4'd1, 'h55}, '{'h000, 'h001, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::ALU, 4'd3, 'h07}, '{'h001, 'h004, 1'b0}, 'h0},
  // Each Jcc once with its condition true and once false
  '{2'b01, 'h800, 'h0, '{tiny86_isa_pkg::JO, 4'd2, 'h10}, '{'h004, 'h016, 1'b1}, 'h0},
  '{2'b01, 'h000, 'h0, '{tiny86_isa_pkg::JO, 4'd2, 'h10}, '{'h016, 'h018, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNO, 4'd2, 'h10}, '{'h018, 'h02a, 1'b1}, 'h0},
  '{2'b01, 'h800, 'h0, '{tiny86_isa_pkg::JNO, 4'd2, 'h10}, '{'h02a, 'h02c, 1'b0}, 'h0},
  '{2'b01, 'h001, 'h0, '{tiny86_isa_pkg::JB, 4'd2, 'h10}, '{'h02c, 'h03e, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JAE, 4'd2, 'h10}, '{'h03e, 'h040, 1'b0}, 'h0},
  '{2'b01, 'h000, 'h0, '{tiny86_isa_pkg::JB, 4'd2, 'h10}, '{'h040, 'h042, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JAE, 4'd2, 'h10}, '{'h042, 'h054, 1'b1}, 'h0},
  '{2'b01, 'h040, 'h0, '{tiny86_isa_pkg::JE, 4'd2, 'h10}, '{'h054, 'h066, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNE, 4'd2, 'h10}, '{'h066, 'h068, 1'b0}, 'h0},
  '{2'b01, 'h000, 'h0, '{tiny86_isa_pkg::JE, 4'd2, 'h10}, '{'h068, 'h06a, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNE, 4'd2, 'h10}, '{'h06a, 'h07c, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JBE, 4'd2, 'h10}, '{'h07c, 'h07e, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JA, 4'd2, 'h10}, '{'h07e, 'h090, 1'b1}, 'h0},
  '{2'b01, 'h041, 'h0, '{tiny86_isa_pkg::JBE, 4'd2, 'h10}, '{'h090, 'h0a2, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JA, 4'd2, 'h10}, '{'h0a2, 'h0a4, 1'b0}, 'h0},
  '{2'b01, 'h080, 'h0, '{tiny86_isa_pkg::JS, 4'd2, 'h10}, '{'h0a4, 'h0b6, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNS, 4'd2, 'h10}, '{'h0b6, 'h0b8, 1'b0}, 'h0},
  '{2'b01, 'h000, 'h0, '{tiny86_isa_pkg::JS, 4'd2, 'h10}, '{'h0b8, 'h0ba, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNS, 4'd2, 'h10}, '{'h0ba, 'h0cc, 1'b1}, 'h0},
  '{2'b01, 'h004, 'h0, '{tiny86_isa_pkg::JP, 4'd2, 'h10}, '{'h0cc, 'h0de, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNP, 4'd2, 'h10}, '{'h0de, 'h0e0, 1'b0}, 'h0},
  '{2'b01, 'h000, 'h0, '{tiny86_isa_pkg::JP, 4'd2, 'h10}, '{'h0e0, 'h0e2, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNP, 4'd2, 'h10}, '{'h0e2, 'h0f4, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JL, 4'd2, 'h10}, '{'h0f4, 'h0f6, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNL, 4'd2, 'h10}, '{'h0f6, 'h108, 1'b1}, 'h0},
  '{2'b01, 'h080, 'h0, '{tiny86_isa_pkg::JL, 4'd2, 'h10}, '{'h108, 'h11a, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JNL, 4'd2, 'h10}, '{'h11a, 'h11c, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JLE, 4'd2, 'h10}, '{'h11c, 'h12e, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JG, 4'd2, 'h10}, '{'h12e, 'h130, 1'b0}, 'h0},
  '{2'b01, 'h880, 'h0, '{tiny86_isa_pkg::JG, 4'd2, 'h10}, '{'h130, 'h142, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JLE, 4'd2, 'h10}, '{'h142, 'h144, 1'b0}, 'h0},
  '{2'b01, 'h8c0, 'h0, '{tiny86_isa_pkg::JLE, 4'd2, 'h10}, '{'h144, 'h156, 1'b1}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JCXZ, 4'd2, 'h10}, '{'h156, 'h168, 1'b1}, 'h0},
  '{2'b10, 'h000, 'h5, '{tiny86_isa_pkg::JCXZ, 4'd2, 'h10}, '{'h168, 'h16a, 1'b0}, 'h5},
  // Unconditional transfers, a negative offset wraps back
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::CALLr, 4'd3, 'h100}, '{'h16a, 'h26d, 1'b1}, 'h5},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::JMPr, 4'd2, 'hffff_ff00}, '{'h26d, 'h16f, 1'b1}, 'h5},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::CALLi, 4'd5, 'h400}, '{'h16f, 'h400, 1'b1}, 'h5},
  '{2'b01, 'h000, 'h0, '{tiny86_isa_pkg::JMPi, 4'd5, 'h500}, '{'h400, 'h500, 1'b1}, 'h5},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::RET, 4'd1, 'h600}, '{'h500, 'h600, 1'b1}, 'h5},
  // Loop family, including the wrap from zero
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::LOOP, 4'd2, 'h10}, '{'h600, 'h612, 1'b1}, 'h4},
  '{2'b10, 'h000, 'h1, '{tiny86_isa_pkg::LOOP, 4'd2, 'h10}, '{'h612, 'h614, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::LOOP, 4'd2, 'h10}, '{'h614, 'h626, 1'b1}, 'hffff_ffff},
  '{2'b01, 'h040, 'h0, '{tiny86_isa_pkg::LOOPE, 4'd2, 'h10}, '{'h626, 'h638, 1'b1}, 'hffff_fffe},
  '{2'b01, 'h000, 'h0, '{tiny86_isa_pkg::LOOPE, 4'd2, 'h10}, '{'h638, 'h63a, 1'b0}, 'hffff_fffd},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::LOOPNE, 4'd2, 'h10}, '{'h63a, 'h64c, 1'b1}, 'hffff_fffc},
  '{2'b11, 'h040, 'h3, '{tiny86_isa_pkg::LOOPNE, 4'd2, 'h10}, '{'h64c, 'h64e, 1'b0}, 'h2},
  '{2'b11, 'h040, 'h1, '{tiny86_isa_pkg::LOOPE, 4'd2, 'h10}, '{'h64e, 'h650, 1'b0}, 'h0},
  '{2'b11, 'h000, 'h1, '{tiny86_isa_pkg::LOOPNE, 4'd2, 'h10}, '{'h650, 'h652, 1'b0}, 'h0},
  '{2'b00, 'h000, 'h0, '{tiny86_isa_pkg::NOP, 4'd2, 'h00}, '{'h652, 'h654, 1'b0}, 'h0}
};

`endif

// File: test/tb_tiny86_ctrl.sv
//------------------
// Testbench for the Tiny86 EIP control path
// Runs the vector table through the instruction port with random commit
// stalls, checks commits in order and register state over APB
//------------------
`timescale 1ns/1ps
`default_nettype none

module tb_tiny86_ctrl;

  logic                     clk;
  logic                     rst_n;
  tiny86_bus_pkg::apb_req_t apb_req;
  tiny86_bus_pkg::apb_rsp_t apb_rsp;
  tiny86_isa_pkg::instr_t   instr;
  logic                     instr_valid;
  logic                     instr_ready;
  tiny86_isa_pkg::commit_t  commit;
  logic                     commit_valid;
  logic                     commit_ready;

  `include "tb_ctrl_vectors.svh"

  // Each row needs at most a few APB transfers plus the handshake
  localparam int TIMEOUT = NUM_VECS * 40 + 200;

  int mismatches;
  int failures;
  int sent;
  int received;
  int cycles;
  logic [31:0] rng;

  // Expected commits in the order the instructions were accepted
  tiny86_isa_pkg::commit_t exp_q[$];
  string                   name_q[$];
  tiny86_isa_pkg::commit_t exp_head;
  string                   name_head;

  tiny86_ctrl_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .commit       (commit),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_commit(input string name, input tiny86_isa_pkg::commit_t exp,
                              input tiny86_isa_pkg::commit_t act);
    if (act !== exp) begin
      mismatches++;
      $display("ERROR %s: expected eip=%h next_eip=%h taken=%b, actual %s", name, exp.eip,
               exp.next_eip, exp.taken,
               $sformatf("eip=%h next_eip=%h taken=%b", act.eip, act.next_eip, act.taken));
    end
  endtask

  task automatic check_reg(input string name, input logic [tiny86_isa_pkg::XLEN-1:0] exp,
                           input logic [tiny86_isa_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Runs one APB setup and access phase and samples the response mid-cycle in the access phase
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    if (apb_rsp.pready !== 1'b1) begin
      failures++;
      $display("APB slave did not answer with pready in the access phase");
    end
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_bit($sformatf("pslverr on write to %h", addr), 1'b0, err);
  endtask

  task automatic reg_read_check(input string name, input logic [3:0] addr,
                                input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, '0, rd, err);
    check_bit({name, " pslverr"}, 1'b0, err);
    check_reg(name, exp, rd);
  endtask

  // Holds the instruction until the retire stage takes it
  task automatic send_instr(input string name, input tiny86_isa_pkg::instr_t ins,
                            input tiny86_isa_pkg::commit_t exp);
    @(posedge clk);
    instr       <= ins;
    instr_valid <= 1'b1;
    @(negedge clk);
    while (!instr_ready) begin
      @(negedge clk);
    end
    exp_q.push_back(exp);
    name_q.push_back(name);
    sent++;
    @(posedge clk);
    instr_valid <= 1'b0;
    // The record sits in the commit slot one cycle after the accept
    @(negedge clk);
    check_bit({name, " commit_valid after accept"}, 1'b1, commit_valid);
  endtask

  // The sink stalls at random in about one cycle out of four
  initial begin
    rng          = 32'h79c7944a;
    commit_ready = 1'b0;
    forever begin
      @(posedge clk);
      rng = xorshift32(rng);
      commit_ready <= (rng[1:0] != 2'b00);
    end
  end

  // A record is consumed at the next edge when valid and ready are both high
  always @(negedge clk) begin
    if (rst_n && commit_valid && commit_ready) begin
      if (exp_q.size() == 0) begin
        failures++;
        $display("A commit record arrived when none was expected");
      end else begin
        exp_head  = exp_q.pop_front();
        name_head = name_q.pop_front();
        check_commit(name_head, exp_head, commit);
      end
      received++;
    end
  end

  initial begin
    cycles = 0;
    while (cycles <= TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    vec_t                    v;
    tiny86_isa_pkg::opcode_e opc;
    tiny86_isa_pkg::instr_t  ins;
    tiny86_isa_pkg::commit_t expc;
    string                   name;
    logic [31:0]             rd;
    logic                    err;
    rst_n       = 1'b0;
    apb_req     = '0;
    instr       = '0;
    instr_valid = 1'b0;
    mismatches  = 0;
    failures    = 0;
    sent        = 0;
    received    = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("reset commit_valid", 1'b0, commit_valid);
    check_bit("reset instr_ready", 1'b1, instr_ready);
    check_bit("reset pslverr", 1'b0, apb_rsp.pslverr);
    reg_read_check("reset eip", tiny86_bus_pkg::REG_EIP, '0);
    reg_read_check("reset eflags", tiny86_bus_pkg::REG_EFLAGS, '0);
    reg_read_check("reset ecx", tiny86_bus_pkg::REG_ECX, '0);

    for (int i = 0; i < NUM_VECS; i++) begin
      v    = vecs[i];
      opc  = v.instr.opc;
      name = $sformatf("row %0d %s", i, opc.name());
      if (v.ld[0]) begin
        reg_write(tiny86_bus_pkg::REG_EFLAGS, v.eflags);
      end
      if (v.ld[1]) begin
        reg_write(tiny86_bus_pkg::REG_ECX, v.ecx);
      end
      send_instr(name, v.instr, v.exp_commit);
      reg_read_check({name, " ecx"}, tiny86_bus_pkg::REG_ECX, v.exp_ecx);
    end

    // Software moves EIP and the next commit starts there
    reg_write(tiny86_bus_pkg::REG_EIP, 'h1000);
    reg_read_check("eip readback", tiny86_bus_pkg::REG_EIP, 'h1000);
    reg_write(tiny86_bus_pkg::REG_EFLAGS, 'h8c5);
    reg_read_check("eflags readback", tiny86_bus_pkg::REG_EFLAGS, 'h8c5);
    ins  = '{opc: tiny86_isa_pkg::NOP, instr_len: 4'd2, address: '0};
    expc = '{eip: 'h1000, next_eip: 'h1002, taken: 1'b0};
    send_instr("nop after eip write", ins, expc);

    // Offset 0xC is unmapped, so both accesses error and change nothing
    apb_xfer(1'b1, 4'hc, 'hdead_beef, rd, err);
    check_bit("unmapped write pslverr", 1'b1, err);
    apb_xfer(1'b0, 4'hc, '0, rd, err);
    check_bit("unmapped read pslverr", 1'b1, err);
    reg_read_check("eip after unmapped write", tiny86_bus_pkg::REG_EIP, 'h1002);
    reg_read_check("eflags after unmapped write", tiny86_bus_pkg::REG_EFLAGS, 'h8c5);
    reg_read_check("ecx after unmapped write", tiny86_bus_pkg::REG_ECX, '0);

    // Let the slot drain before counting
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    if (received != sent) begin
      failures++;
      $display("Sent %0d instructions but received %0d commit records", sent, received);
    end
    $display("Summary: %0d value mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
